// File: design/bridge_pkg.sv
package bridge_pkg;

  // basic widths
  typedef logic [7:0]  byte_t;      // cmd, data or reply byte
  typedef logic [7:0]  ram_addr_t;  // scratch index
  typedef logic [15:0] word_t;      // data word for downstream
  typedef logic [23:0] mem_addr_t;  // downstream memory address

  // executor fsm
  typedef enum logic [1:0] {
    EXEC_IDLE,      // waiting for a frame
    EXEC_RUN,       // decode and execute
    EXEC_WAIT_RSP   // reply path still busy
  } exec_state_t;

  // serial framing
  localparam int CMD_FRAME_BITS = 16;  // cmd + data, after start bit
  localparam int RSP_FRAME_BITS = 18;  // start, two bytes, stop

  localparam byte_t RSP_TAG = 8'h12;   // first echo byte

  // scratch memory
  localparam byte_t OP_RAM_ADDR = 8'h01;
  localparam byte_t OP_RAM_WR   = 8'h02;
  localparam byte_t OP_RAM_RD   = 8'h03;

  // data word bytes
  localparam byte_t OP_DATA_LO  = 8'h10;
  localparam byte_t OP_DATA_HI  = 8'h11;

  // memory address bytes, low to high
  localparam byte_t OP_ADDR_B0  = 8'h12;
  localparam byte_t OP_ADDR_B1  = 8'h13;
  localparam byte_t OP_ADDR_B2  = 8'h14;

  // display control
  localparam byte_t OP_MODE_LO  = 8'h21;  // mode 0
  localparam byte_t OP_MODE_HI  = 8'h22;  // mode 1
  localparam byte_t OP_DISP_OFF = 8'h23;
  localparam byte_t OP_DISP_ON  = 8'h24;

  // link test
  localparam byte_t OP_ECHO     = 8'h30;

endpackage

// File: design/host_link_rx.sv
module host_link_rx (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                host_strobe,   // async from host
  input  logic                host_cmd_bit,  // async from host
  input  logic                frame_ack,
  output logic                strobe_tick,   // one pulse per rising strobe
  output logic                frame_req,
  output bridge_pkg::byte_t   frame_cmd,
  output bridge_pkg::byte_t   frame_dat
);

  localparam int CNT_W = $clog2(bridge_pkg::CMD_FRAME_BITS + 1);

  logic strobe_s1, strobe_s2, strobe_s3;  // sync chain plus edge flop
  logic cmd_s1, cmd_s2;                   // same depth as strobe

  logic [CNT_W-1:0] bit_cnt;  // 0 idle, 1..16 payload bits
  logic [bridge_pkg::CMD_FRAME_BITS-1:0] shift_q;
  logic [bridge_pkg::CMD_FRAME_BITS-1:0] shift_nxt;
  logic last_bit;    // tick carrying the 16th payload bit
  logic frame_load;  // frame complete and slot free

  assign strobe_tick = strobe_s2 & ~strobe_s3;

  // lsb arrives first, new bits enter at the top
  assign shift_nxt  = {cmd_s2, shift_q[bridge_pkg::CMD_FRAME_BITS-1:1]};
  assign last_bit   = strobe_tick && (bit_cnt == CNT_W'(bridge_pkg::CMD_FRAME_BITS));
  assign frame_load = last_bit && !frame_req;  // busy slot drops the frame

  // synchronizers
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      strobe_s1 <= 1'b0;
      strobe_s2 <= 1'b0;
      strobe_s3 <= 1'b0;
      cmd_s1    <= 1'b0;
      cmd_s2    <= 1'b0;
    end else begin
      strobe_s1 <= host_strobe;
      strobe_s2 <= strobe_s1;
      strobe_s3 <= strobe_s2;
      cmd_s1    <= host_cmd_bit;
      cmd_s2    <= cmd_s1;
    end
  end

  // bit counter and request flag
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt   <= '0;
      frame_req <= 1'b0;
    end else begin
      if (strobe_tick) begin
        if (bit_cnt == '0) begin
          if (cmd_s2) begin
            bit_cnt <= CNT_W'(1);  // start bit seen
          end
        end else if (last_bit) begin
          bit_cnt <= '0;  // back to hunting for a start bit
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end

      if (frame_load) begin
        frame_req <= 1'b1;
      end else if (frame_req && frame_ack) begin
        frame_req <= 1'b0;  // executor took it
      end
    end
  end

  // payload capture, held while frame_req is up
  always_ff @(posedge sys_clk) begin
    if (strobe_tick && (bit_cnt != '0)) begin
      shift_q <= shift_nxt;
    end
    if (frame_load) begin
      frame_cmd <= shift_nxt[7:0];
      frame_dat <= shift_nxt[15:8];
    end
  end

endmodule

// File: design/host_link_tx.sv
module host_link_tx (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                strobe_tick,  // from rx sync
  input  logic                rsp_req,
  input  bridge_pkg::byte_t   rsp_byte0,    // sent first
  input  bridge_pkg::byte_t   rsp_byte1,
  output logic                rsp_ack,
  output logic                host_rsp_bit
);

  localparam int CNT_W = $clog2(bridge_pkg::RSP_FRAME_BITS + 1);

  logic [CNT_W-1:0] bit_cnt;  // bits already on the line
  logic [bridge_pkg::RSP_FRAME_BITS-1:0] rsp_frame;

  // stop, byte1, byte0, start... bit 0 goes out first
  assign rsp_frame = {1'b0, rsp_byte1, rsp_byte0, 1'b1};

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt      <= '0;
      rsp_ack      <= 1'b0;
      host_rsp_bit <= 1'b0;
    end else begin
      if (!rsp_req) begin
        // req gone, ready for the next reply
        bit_cnt <= '0;
        rsp_ack <= 1'b0;
      end else if (strobe_tick && !rsp_ack) begin
        if (bit_cnt == CNT_W'(bridge_pkg::RSP_FRAME_BITS)) begin
          rsp_ack <= 1'b1;  // tick after the stop bit
        end else begin
          host_rsp_bit <= rsp_frame[bit_cnt];
          bit_cnt      <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // line idles low
  // stop bit is 0 so nothing else needed after a frame

endmodule

// File: design/cmd_exec.sv
module cmd_exec (
  input  logic                    sys_clk,
  input  logic                    sys_rst_n,
  input  logic                    frame_req,
  input  bridge_pkg::byte_t       frame_cmd,
  input  bridge_pkg::byte_t       frame_dat,
  input  logic                    rsp_ack,
  input  bridge_pkg::byte_t       ram_rdata,   // one cycle after ram_addr
  output logic                    frame_ack,
  output logic                    busy,
  output logic                    rsp_req,
  output bridge_pkg::byte_t       rsp_byte0,
  output bridge_pkg::byte_t       rsp_byte1,
  output logic                    ram_we,
  output bridge_pkg::ram_addr_t   ram_addr,
  output bridge_pkg::byte_t       ram_wdata,
  output bridge_pkg::mem_addr_t   mem_addr,
  output bridge_pkg::word_t       mem_wdata,
  output logic                    disp_mode,
  output logic                    disp_enable
);

  bridge_pkg::exec_state_t state;

  logic                  req_q;     // frame_req registered once
  bridge_pkg::byte_t     cmd_q;     // latched opcode
  bridge_pkg::byte_t     dat_q;     // latched data byte
  bridge_pkg::ram_addr_t wr_ptr;    // set by OP_RAM_ADDR
  logic                  rd_phase;  // second cycle of a scratch read

  logic              latch;       // take a new frame
  logic              is_rd;
  logic              wants_reply; // reply ready to hand over
  logic              rsp_free;    // tx handshake fully idle
  logic              rsp_load;
  bridge_pkg::byte_t rsp0_nxt;
  bridge_pkg::byte_t rsp1_nxt;

  assign latch    = (state == bridge_pkg::EXEC_IDLE) && req_q && !frame_ack;
  assign is_rd    = (cmd_q == bridge_pkg::OP_RAM_RD);
  assign rsp_free = !rsp_req && !rsp_ack;

  // echo or read data, or a reply left waiting
  assign wants_reply = ((state == bridge_pkg::EXEC_RUN) &&
                        ((cmd_q == bridge_pkg::OP_ECHO) || (is_rd && rd_phase))) ||
                       (state == bridge_pkg::EXEC_WAIT_RSP);
  assign rsp_load    = wants_reply && rsp_free;

  assign rsp0_nxt = is_rd ? ram_rdata : bridge_pkg::RSP_TAG;
  assign rsp1_nxt = is_rd ? 8'h00 : dat_q;

  // scratch port, reads address the data byte directly
  assign ram_addr  = is_rd ? dat_q : wr_ptr;
  assign ram_wdata = dat_q;
  assign ram_we    = (state == bridge_pkg::EXEC_RUN) && (cmd_q == bridge_pkg::OP_RAM_WR);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= bridge_pkg::EXEC_IDLE;
      req_q       <= 1'b0;
      frame_ack   <= 1'b0;
      busy        <= 1'b0;
      rsp_req     <= 1'b0;
      rd_phase    <= 1'b0;
      wr_ptr      <= '0;
      mem_addr    <= '0;
      mem_wdata   <= '0;
      disp_mode   <= 1'b1;  // high mode by default
      disp_enable <= 1'b0;  // display blocked until turned on
    end else begin
      req_q <= frame_req;

      if (!req_q && frame_ack) begin
        frame_ack <= 1'b0;  // rx has dropped its req
      end
      if (rsp_req && rsp_ack) begin
        rsp_req <= 1'b0;
      end

      unique case (state)
        bridge_pkg::EXEC_IDLE: begin
          if (latch) begin
            frame_ack <= 1'b1;
            busy      <= 1'b1;
            state     <= bridge_pkg::EXEC_RUN;
          end
        end

        bridge_pkg::EXEC_RUN: begin
          if (is_rd && !rd_phase) begin
            rd_phase <= 1'b1;  // let ram_rdata settle
          end else if (wants_reply && !rsp_free) begin
            state <= bridge_pkg::EXEC_WAIT_RSP;  // previous reply still out
          end else begin
            state    <= bridge_pkg::EXEC_IDLE;
            busy     <= 1'b0;
            rd_phase <= 1'b0;
            if (rsp_load) begin
              rsp_req <= 1'b1;
            end
            case (cmd_q)
              bridge_pkg::OP_RAM_ADDR: wr_ptr            <= dat_q;
              bridge_pkg::OP_DATA_LO:  mem_wdata[7:0]    <= dat_q;
              bridge_pkg::OP_DATA_HI:  mem_wdata[15:8]   <= dat_q;
              bridge_pkg::OP_ADDR_B0:  mem_addr[7:0]     <= dat_q;
              bridge_pkg::OP_ADDR_B1:  mem_addr[15:8]    <= dat_q;
              bridge_pkg::OP_ADDR_B2:  mem_addr[23:16]   <= dat_q;
              bridge_pkg::OP_MODE_LO:  disp_mode         <= 1'b0;
              bridge_pkg::OP_MODE_HI:  disp_mode         <= 1'b1;
              bridge_pkg::OP_DISP_OFF: disp_enable       <= 1'b0;
              bridge_pkg::OP_DISP_ON:  disp_enable       <= 1'b1;
              default: ;  // writes, replies and unknown opcodes
            endcase
          end
        end

        bridge_pkg::EXEC_WAIT_RSP: begin
          if (rsp_free) begin
            rsp_req  <= 1'b1;
            busy     <= 1'b0;
            rd_phase <= 1'b0;
            state    <= bridge_pkg::EXEC_IDLE;
          end
        end

        default: state <= bridge_pkg::EXEC_IDLE;
      endcase
    end
  end

  // command and reply payload
  always_ff @(posedge sys_clk) begin
    if (latch) begin
      cmd_q <= frame_cmd;
      dat_q <= frame_dat;
    end
    if (rsp_load) begin
      rsp_byte0 <= rsp0_nxt;  // read data stays valid while waiting
      rsp_byte1 <= rsp1_nxt;
    end
  end

endmodule

// File: design/scratch_ram.sv
module scratch_ram (
  input  logic                    sys_clk,
  input  logic                    ram_we,
  input  bridge_pkg::ram_addr_t   ram_addr,
  input  bridge_pkg::byte_t       ram_wdata,
  output bridge_pkg::byte_t       ram_rdata
);

  bridge_pkg::byte_t mem [256];  // contents undefined until written

  always_ff @(posedge sys_clk) begin
    if (ram_we) begin
      mem[ram_addr] <= ram_wdata;
    end
    ram_rdata <= mem[ram_addr];  // registered read, old data on a write
  end

endmodule

// File: design/usb_cmd_bridge.sv
module usb_cmd_bridge (
  input  logic                    sys_clk,
  input  logic                    sys_rst_n,
  input  logic                    host_strobe,   // host bit clock, sampled
  input  logic                    host_cmd_bit,
  output logic                    host_rsp_bit,
  output logic                    busy,
  output bridge_pkg::mem_addr_t   mem_addr,
  output bridge_pkg::word_t       mem_wdata,
  output logic                    disp_mode,
  output logic                    disp_enable
);

  // rx to exec
  logic              strobe_tick;
  logic              frame_req;
  logic              frame_ack;
  bridge_pkg::byte_t frame_cmd;
  bridge_pkg::byte_t frame_dat;

  // exec to tx
  logic              rsp_req;
  logic              rsp_ack;
  bridge_pkg::byte_t rsp_byte0;
  bridge_pkg::byte_t rsp_byte1;

  // exec to scratch
  logic                  ram_we;
  bridge_pkg::ram_addr_t ram_addr;
  bridge_pkg::byte_t     ram_wdata;
  bridge_pkg::byte_t     ram_rdata;

  host_link_rx u_rx (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .host_strobe  (host_strobe),
    .host_cmd_bit (host_cmd_bit),
    .frame_ack    (frame_ack),
    .strobe_tick  (strobe_tick),
    .frame_req    (frame_req),
    .frame_cmd    (frame_cmd),
    .frame_dat    (frame_dat)
  );

  host_link_tx u_tx (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .strobe_tick  (strobe_tick),  // shares the rx strobe sync
    .rsp_req      (rsp_req),
    .rsp_byte0    (rsp_byte0),
    .rsp_byte1    (rsp_byte1),
    .rsp_ack      (rsp_ack),
    .host_rsp_bit (host_rsp_bit)
  );

  cmd_exec u_exec (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .frame_req   (frame_req),
    .frame_cmd   (frame_cmd),
    .frame_dat   (frame_dat),
    .rsp_ack     (rsp_ack),
    .ram_rdata   (ram_rdata),
    .frame_ack   (frame_ack),
    .busy        (busy),
    .rsp_req     (rsp_req),
    .rsp_byte0   (rsp_byte0),
    .rsp_byte1   (rsp_byte1),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .disp_mode   (disp_mode),
    .disp_enable (disp_enable)
  );

  scratch_ram u_ram (
    .sys_clk   (sys_clk),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

// File: tb/bridge_props.sv
module bridge_props (
  input logic                    sys_clk,
  input logic                    sys_rst_n,
  input logic                    frame_req,
  input logic                    frame_ack,
  input logic                    rsp_req,
  input logic                    rsp_ack,
  input logic                    busy,
  input bridge_pkg::exec_state_t state
);

  int prop_fails = 0;  // polled by the testbench

  // rx keeps its frame up until the executor takes it
  frame_req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    frame_req && !frame_ack |=> frame_req)
  else begin
    $error("frame_req dropped before frame_ack");
    prop_fails++;
  end

  // same rule on the reply side
  rsp_req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    rsp_req && !rsp_ack |=> rsp_req)
  else begin
    $error("rsp_req dropped before rsp_ack");
    prop_fails++;
  end

  // idle executor is never busy
  idle_not_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    (state == bridge_pkg::EXEC_IDLE) |-> !busy)
  else begin
    $error("busy high while executor idle");
    prop_fails++;
  end

endmodule

bind cmd_exec bridge_props u_props (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .frame_req (frame_req),
  .frame_ack (frame_ack),
  .rsp_req   (rsp_req),
  .rsp_ack   (rsp_ack),
  .busy      (busy),
  .state     (state)
);

// File: tb/tb_usb_cmd_bridge.sv
module tb_usb_cmd_bridge;

  localparam int NUM_CMDS    = 300;  // random commands
  localparam int WARM_CMDS   = 32;   // scratch fill, addr + write per entry
  localparam int CYC_PER_CMD = 500;  // frame plus reply is about 440 cycles
  localparam int CYCLE_LIMIT = (NUM_CMDS + WARM_CMDS) * CYC_PER_CMD;
  localparam int HALF_BIT    = 6;    // sys_clk cycles per strobe phase
  localparam logic [7:0] ECHO_TAG = 8'h12;

  logic                  sys_clk;
  logic                  sys_rst_n;
  logic                  host_strobe;
  logic                  host_cmd_bit;
  logic                  host_rsp_bit;
  logic                  busy;
  bridge_pkg::mem_addr_t mem_addr;
  bridge_pkg::word_t     mem_wdata;
  logic                  disp_mode;
  logic                  disp_enable;

  logic [31:0] lfsr;
  int          cycle_cnt  = 0;
  int          busy_rises = 0;  // counted at falling edges
  logic        busy_prev  = 1'b0;
  logic [7:0]  known_ops [13];

  // reference model of the bridge state
  logic [7:0]  mdl_mem [256];
  logic [7:0]  mdl_ptr;
  logic [23:0] mdl_addr;
  logic [15:0] mdl_word;
  logic        mdl_mode;
  logic        mdl_en;

  usb_cmd_bridge u_dut (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .host_strobe  (host_strobe),
    .host_cmd_bit (host_cmd_bit),
    .host_rsp_bit (host_rsp_bit),
    .busy         (busy),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .disp_mode    (disp_mode),
    .disp_enable  (disp_enable)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  task automatic fail_now(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // cycle limit, busy edges, bound handshake checks
  always @(negedge sys_clk) begin
    cycle_cnt++;
    if (busy && !busy_prev) begin
      busy_rises++;
    end
    busy_prev = busy;
    assert (cycle_cnt < CYCLE_LIMIT) else fail_now("run went past the cycle limit");
    assert (u_dut.u_exec.u_props.prop_fails == 0) else
      fail_now("a bound handshake assertion fired");
  end

  // galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  function automatic logic is_known(input logic [7:0] op);
    logic hit;
    hit = 1'b0;
    foreach (known_ops[i]) begin
      hit = hit | (known_ops[i] == op);
    end
    return hit;
  endfunction

  // 16 scratch entries spread over the whole byte
  function automatic logic [7:0] scratch_addr(input logic [3:0] idx);
    return {idx, idx ^ 4'h9};
  endfunction

  // one bit slot: low phase with the new cmd bit, then high phase
  task automatic strobe_bit(input logic cmd_bit, output logic rsp_bit);
    @(negedge sys_clk);
    host_cmd_bit = cmd_bit;  // only moves while strobe is low
    repeat (HALF_BIT - 1) @(negedge sys_clk);
    host_strobe = 1'b1;
    repeat (HALF_BIT) @(negedge sys_clk);
    rsp_bit     = host_rsp_bit;  // sampled at the strobe fall
    host_strobe = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] cmd, input logic [7:0] dat);
    logic [15:0] payload;
    logic        b;
    payload = {dat, cmd};  // cmd goes out first, lsb first
    strobe_bit(1'b1, b);
    check_val("host_rsp_bit", b, 1'b0);
    for (int i = 0; i < 16; i++) begin
      strobe_bit(payload[i], b);
      check_val("host_rsp_bit", b, 1'b0);  // no reply left over
    end
  endtask

  task automatic get_reply(output logic [15:0] rsp);
    logic b;
    int   waited;
    b      = 1'b0;
    waited = 0;
    while (!b) begin
      strobe_bit(1'b0, b);
      waited++;
      assert (waited <= 4) else fail_now("reply start bit never came");
    end
    for (int i = 0; i < 16; i++) begin
      strobe_bit(1'b0, b);
      rsp[i] = b;
    end
    strobe_bit(1'b0, b);
    check_val("rsp stop bit", b, 1'b0);
    strobe_bit(1'b0, b);  // ack tick
    check_val("host_rsp_bit idle", b, 1'b0);
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy) begin
      @(negedge sys_clk);
      n++;
      assert (n < 50) else fail_now("busy stuck high after a command");
    end
  endtask

  task automatic check_outputs();
    check_val("mem_addr", mem_addr, mdl_addr);
    check_val("mem_wdata", mem_wdata, mdl_word);
    check_val("disp_mode", disp_mode, mdl_mode);
    check_val("disp_enable", disp_enable, mdl_en);
    check_val("busy", busy, 1'b0);
    check_val("host_rsp_bit", host_rsp_bit, 1'b0);
  endtask

  task automatic run_cmd(input logic [7:0] cmd, input logic [7:0] dat);
    logic [15:0] rsp;
    logic [15:0] exp_rsp;
    logic        expect_rsp;
    logic        b;
    int          rises_before;
    rises_before = busy_rises;
    expect_rsp   = 1'b0;
    exp_rsp      = '0;
    case (cmd)
      bridge_pkg::OP_RAM_ADDR: mdl_ptr = dat;
      bridge_pkg::OP_RAM_WR:   mdl_mem[mdl_ptr] = dat;
      bridge_pkg::OP_RAM_RD: begin
        expect_rsp = 1'b1;
        exp_rsp    = {8'h00, mdl_mem[dat]};  // read uses the data byte as index
      end
      bridge_pkg::OP_DATA_LO:  mdl_word[7:0]   = dat;
      bridge_pkg::OP_DATA_HI:  mdl_word[15:8]  = dat;
      bridge_pkg::OP_ADDR_B0:  mdl_addr[7:0]   = dat;
      bridge_pkg::OP_ADDR_B1:  mdl_addr[15:8]  = dat;
      bridge_pkg::OP_ADDR_B2:  mdl_addr[23:16] = dat;
      bridge_pkg::OP_MODE_LO:  mdl_mode = 1'b0;
      bridge_pkg::OP_MODE_HI:  mdl_mode = 1'b1;
      bridge_pkg::OP_DISP_OFF: mdl_en   = 1'b0;
      bridge_pkg::OP_DISP_ON:  mdl_en   = 1'b1;
      bridge_pkg::OP_ECHO: begin
        expect_rsp = 1'b1;
        exp_rsp    = {dat, ECHO_TAG};
      end
      default: ;  // unknown, nothing changes
    endcase
    send_frame(cmd, dat);
    if (expect_rsp) begin
      get_reply(rsp);
      check_val("rsp_byte0", rsp[7:0], exp_rsp[7:0]);
      check_val("rsp_byte1", rsp[15:8], exp_rsp[15:8]);
    end else begin
      repeat (2) begin
        strobe_bit(1'b0, b);
        check_val("host_rsp_bit", b, 1'b0);  // silent command
      end
    end
    wait_not_busy();
    check_val("busy rises", busy_rises - rises_before, 1);
    check_outputs();
  endtask

  task automatic pick_cmd(output logic [7:0] cmd, output logic [7:0] dat);
    logic [7:0] sel;
    logic [7:0] r;
    draw_bits(5, sel);
    if (sel >= 8'd30) begin
      draw_bits(8, cmd);  // occasional unknown opcode
      while (is_known(cmd)) begin
        draw_bits(8, cmd);
      end
    end else begin
      cmd = known_ops[sel % 13];
    end
    if (cmd == bridge_pkg::OP_RAM_ADDR || cmd == bridge_pkg::OP_RAM_RD) begin
      draw_bits(4, r);
      dat = scratch_addr(r[3:0]);
    end else begin
      draw_bits(8, dat);
    end
  endtask

  initial begin
    logic [7:0] cmd;
    logic [7:0] dat;
    sys_rst_n    = 1'b0;
    host_strobe  = 1'b0;
    host_cmd_bit = 1'b0;
    lfsr         = 32'ha2e2e88b;
    known_ops    = '{bridge_pkg::OP_RAM_ADDR, bridge_pkg::OP_RAM_WR, bridge_pkg::OP_RAM_RD,
                     bridge_pkg::OP_DATA_LO, bridge_pkg::OP_DATA_HI, bridge_pkg::OP_ADDR_B0,
                     bridge_pkg::OP_ADDR_B1, bridge_pkg::OP_ADDR_B2, bridge_pkg::OP_MODE_LO,
                     bridge_pkg::OP_MODE_HI, bridge_pkg::OP_DISP_OFF, bridge_pkg::OP_DISP_ON,
                     bridge_pkg::OP_ECHO};
    mdl_ptr  = '0;
    mdl_addr = '0;
    mdl_word = '0;
    mdl_mode = 1'b1;  // reset values
    mdl_en   = 1'b0;
    repeat (8) @(negedge sys_clk);
    sys_rst_n = 1'b1;
    @(negedge sys_clk);
    check_outputs();
    // fill the 16 scratch entries so reads never see unwritten data
    for (int i = 0; i < 16; i++) begin
      run_cmd(bridge_pkg::OP_RAM_ADDR, scratch_addr(i[3:0]));
      draw_bits(8, dat);
      run_cmd(bridge_pkg::OP_RAM_WR, dat);
    end
    for (int n = 0; n < NUM_CMDS; n++) begin
      pick_cmd(cmd, dat);
      run_cmd(cmd, dat);
    end
    if (u_dut.u_exec.u_props.prop_fails == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "handshake assertion failures seen");
    end
  end

endmodule

// File: sim.f
design/bridge_pkg.sv
design/host_link_rx.sv
design/host_link_tx.sv
design/cmd_exec.sv
design/scratch_ram.sv
design/usb_cmd_bridge.sv
tb/bridge_props.sv
tb/tb_usb_cmd_bridge.sv
